// File: files.f
cpu_pkg.sv
ctrl_if.sv
control_decoder.sv
phase_fsm.sv
program_counter.sv
alu_unit.sv
register_file.sv
cpu_core.sv
tb_clock_gen.sv
tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu
    import cpu_pkg::*;
();

    localparam int          PC_W          = 32;
    localparam int          NUM_REGS      = 32;
    localparam int          IMEM_WORDS    = 256;
    localparam int          DMEM_WORDS    = 512;
    localparam int          STORE_TIMEOUT = 200;
    localparam int          IDLE_TIMEOUT  = 100;
    localparam logic [15:0] BAD_ADDR      = 16'h07F0;     // Target of wrong-path stores

    logic              clk;
    logic              reset;
    logic [PC_W-1:0]   imem_addr;
    logic [DATA_W-1:0] imem_data;
    logic [DATA_W-1:0] dmem_addr;
    logic [DATA_W-1:0] dmem_wdata;
    logic              dmem_we;
    logic              dmem_re;
    logic [DATA_W-1:0] dmem_rdata;

    logic [DATA_W-1:0] imem [IMEM_WORDS];
    logic [DATA_W-1:0] dmem [DMEM_WORDS];

    // Program and expected stores, in execution order
    logic [DATA_W-1:0] prog [$];
    logic [DATA_W-1:0] exp_addr [$];
    logic [DATA_W-1:0] exp_data [$];

    // Architectural state as the instruction rules define it
    logic [DATA_W-1:0] regm [NUM_REGS];
    logic              zf;
    logic              sf;
    logic              cf;
    int                st_ptr;
    int                loads_expected;
    int                re_count = 0;
    logic              re_last  = 1'b0;
    logic [PC_W-1:0]   idle_addr;

    tb_clock_gen #(.PERIOD(4)) u_clk (.clk(clk));

    cpu_core #(.PC_W(PC_W), .NUM_REGS(NUM_REGS)) u_dut (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[10:2]];       // Same-cycle read

    //////////////////////////////////////////////////
    // Reporting and compares
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input string name, input logic [DATA_W-1:0] actual,
                              input logic [DATA_W-1:0] expected);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] actual,
                              input logic [DATA_W-1:0] expected);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: got %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_strobe(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("FAIL %0t %s: got %b, expected %b", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected)
        begin
            $display("FAIL %0t %s: got %0d, expected %0d", $time, name, actual, expected);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Program builder with reference model
    //////////////////////////////////////////////////

    function automatic logic [DATA_W-1:0] sext(input logic [15:0] v);
        return {{(DATA_W-16){v[15]}}, v};
    endfunction

    function automatic logic [DATA_W-1:0] image_word(input int idx);
        case (idx)
            1:       return 32'hF0F0_1234;   // Negative, for arithmetic shifts
            2:       return 32'h7FFF_FFFF;
            3:       return 32'hFFFF_FFFF;
            default: return (DATA_W'(idx) * 32'h9E37_79B9) ^ {16'h5A5A, 16'(idx)};
        endcase
    endfunction

    task automatic alu_write(input logic [4:0] rd, input logic [DATA_W:0] wide,
                             input logic arith);
        if (rd != 5'd0)
            regm[rd] = wide[DATA_W-1:0];
        zf = (wide[DATA_W-1:0] == '0);
        sf = wide[DATA_W-1];
        cf = arith ? wide[DATA_W] : 1'b0;      // Logic and shifts clear carry
    endtask

    // Two-address form, rs is source and destination
    task automatic rtype(input func_t fn, input logic [4:0] rs, input logic [4:0] rt,
                         input logic [4:0] sh);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] r;
        logic [4:0]        amt;
        logic [DATA_W:0]   w;
        a   = regm[rs];
        b   = regm[rt];
        amt = (fn inside {FN_SLL_IMM, FN_SRL_IMM, FN_SRA_IMM}) ? sh : b[4:0];
        case (fn)
            FN_AND:                 r = a & b;
            FN_XOR:                 r = a ^ b;
            FN_SLL_IMM, FN_SLL_REG: r = a << amt;
            FN_SRL_IMM, FN_SRL_REG: r = a >> amt;
            default:                r = $signed(a) >>> amt;
        endcase
        if (fn == FN_ADD)
            w = {1'b0, a} + {1'b0, b};
        else if (fn == FN_COMP)
            w = {1'b0, ~b} + 33'd1;
        else
            w = {1'b0, r};
        alu_write(rs, w, fn inside {FN_ADD, FN_COMP});
        prog.push_back({OP_RTYPE, rs, rt, sh, fn});
    endtask

    task automatic imm_op(input opcode_t op, input logic [4:0] r, input logic [15:0] imm);
        logic [DATA_W:0] w;
        if (op == OP_COMPI)
            w = {1'b0, ~sext(imm)} + 33'd1;
        else
            w = {1'b0, regm[r]} + {1'b0, sext(imm)};
        alu_write(r, w, 1'b1);
        prog.push_back({op, r, 5'd0, imm});
    endtask

    task automatic load(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
        logic [DATA_W-1:0] addr;
        addr = regm[rs] + sext(imm);
        if (rt != 5'd0)
            regm[rt] = image_word(int'(addr[10:2]));
        loads_expected++;
        prog.push_back({OP_LOAD, rs, rt, imm});
    endtask

    task automatic store(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm,
                         input bit expected);
        if (expected)
        begin
            exp_addr.push_back(regm[rs] + sext(imm));
            exp_data.push_back(regm[rt]);
        end
        prog.push_back({OP_STORE, rs, rt, imm});
    endtask

    task automatic store_next(input logic [4:0] rt);
        store(rt, 5'd0, 16'(st_ptr), 1'b1);     // Result area
        st_ptr += 4;
    endtask

    // Branch over one store, which is the wrong path when taken
    task automatic branch_over(input opcode_t op, input bit want_taken);
        bit taken;
        case (op)
            OP_BRN:  taken = sf;
            OP_BRZ:  taken = zf;
            OP_BRNZ: taken = !zf;
            OP_BRC:  taken = cf;
            OP_BRNC: taken = !cf;
            default: taken = 1'b1;
        endcase
        if (taken != want_taken)
        begin
            $display("Program table error: branch opcode %0d misses its intended path", op);
            stop_run();
        end
        prog.push_back({op, 5'd0, 5'd0, 16'd1});
        if (taken)
            store(5'd0, 5'd0, BAD_ADDR, 1'b0);
        else
            store_next(5'd0);
    endtask

    task automatic call_and_return();
        logic [DATA_W-1:0] ret;
        int                sub_store;
        int                ret_store;
        ret       = DATA_W'((prog.size() + 1) * 4);
        sub_store = st_ptr;
        ret_store = st_ptr + 4;
        st_ptr   += 8;
        regm[31]  = ret;
        prog.push_back({OP_BL, 5'd31, 5'd0, 16'd2});                    // Call
        prog.push_back({OP_STORE, 5'd0, 5'd31, 16'(ret_store)});        // Return point
        prog.push_back({OP_BR, 5'd0, 5'd0, 16'd2});                     // Over the callee
        prog.push_back({OP_STORE, 5'd0, 5'd31, 16'(sub_store)});        // Callee
        prog.push_back({OP_JR, 5'd31, 5'd0, 16'd0});
        exp_addr.push_back(DATA_W'(sub_store));
        exp_data.push_back(ret);
        exp_addr.push_back(DATA_W'(ret_store));
        exp_data.push_back(ret);
    endtask

    task automatic build_program();
        logic [15:0] amt16;
        st_ptr         = 'h400;
        loads_expected = 0;
        zf             = 1'b0;
        sf             = 1'b0;
        cf             = 1'b0;
        for (int i = 0; i < NUM_REGS; i++)
            regm[i] = '0;

        // Preset registers from the data image
        load(5'd1, 5'd0, 16'h0010);
        load(5'd2, 5'd0, 16'h0004);
        load(5'd3, 5'd0, 16'h0008);
        load(5'd4, 5'd0, 16'h000C);
        load(5'd5, 5'd0, 16'h0014);

        rtype(FN_ADD, 5'd1, 5'd5, 5'd0);  store_next(5'd1);
        rtype(FN_COMP, 5'd6, 5'd2, 5'd0); store_next(5'd6);
        rtype(FN_AND, 5'd5, 5'd2, 5'd0);  store_next(5'd5);
        rtype(FN_XOR, 5'd3, 5'd1, 5'd0);  store_next(5'd3);
        rtype(FN_ADD, 5'd4, 5'd4, 5'd0);  store_next(5'd4);   // Carry out

        for (int k = 0; k < 4; k++)
        begin
            imm_op(OP_ADDI, 5'd1, 16'($urandom));
            store_next(5'd1);
        end
        imm_op(OP_COMPI, 5'd7, 16'($urandom)); store_next(5'd7);

        // Shifts, register amount held in r8
        amt16 = 16'(($urandom % 31) + 1);
        imm_op(OP_COMPI, 5'd8, ~amt16 + 16'd1);
        rtype(FN_SRA_IMM, 5'd2, 5'd0, 5'd9);  store_next(5'd2);
        rtype(FN_SRA_REG, 5'd4, 5'd8, 5'd0);  store_next(5'd4);
        rtype(FN_SLL_IMM, 5'd3, 5'd0, 5'd4);  store_next(5'd3);
        rtype(FN_SRL_IMM, 5'd5, 5'd0, 5'd17); store_next(5'd5);
        rtype(FN_SLL_REG, 5'd1, 5'd8, 5'd0);  store_next(5'd1);
        rtype(FN_SRL_REG, 5'd2, 5'd8, 5'd0);  store_next(5'd2);

        // Load, modify, store through base r10 = 0x600
        imm_op(OP_COMPI, 5'd10, 16'hFA00);
        load(5'd11, 5'd10, 16'hFA0C);
        imm_op(OP_ADDI, 5'd11, 16'h0123);
        store(5'd11, 5'd10, 16'h0024, 1'b1);
        load(5'd12, 5'd10, 16'hFA14);
        rtype(FN_XOR, 5'd12, 5'd1, 5'd0);
        store(5'd12, 5'd10, 16'h0028, 1'b1);

        imm_op(OP_COMPI, 5'd13, 16'h0005);    // -5
        branch_over(OP_BRN, 1'b1);
        branch_over(OP_BRZ, 1'b0);
        branch_over(OP_BRNZ, 1'b1);
        imm_op(OP_COMPI, 5'd14, 16'hFFF0);    // +16
        branch_over(OP_BRN, 1'b0);
        rtype(FN_XOR, 5'd14, 5'd14, 5'd0);
        branch_over(OP_BRZ, 1'b1);
        branch_over(OP_BRNZ, 1'b0);
        imm_op(OP_COMPI, 5'd15, 16'h0001);
        imm_op(OP_ADDI, 5'd15, 16'h0001);     // Wraps to zero with carry
        branch_over(OP_BRC, 1'b1);
        branch_over(OP_BRNC, 1'b0);
        imm_op(OP_ADDI, 5'd15, 16'h0001);
        branch_over(OP_BRC, 1'b0);
        branch_over(OP_BRNC, 1'b1);
        branch_over(OP_BR, 1'b1);

        call_and_return();
        idle_addr = PC_W'(prog.size() * 4);
        prog.push_back({OP_BR, 5'd0, 5'd0, 16'hFFFF});      // Branch to self
    endtask

    //////////////////////////////////////////////////
    // Run
    //////////////////////////////////////////////////

    task automatic wait_store(input int idx);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!dmem_we && cycles < STORE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!dmem_we)
        begin
            $display("Timed out waiting for store number %0d", idx);
            stop_run();
        end
    endtask

    // Each load strobe lasts one cycle
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (dmem_re && re_last)
            begin
                $display("dmem_re stayed high for more than one cycle at %0t", $time);
                stop_run();
            end
            if (dmem_re)
                re_count++;
            re_last = dmem_re;
        end
    end

    initial
    begin
        int cycles;
        reset = 1'b1;
        void'($urandom(13));
        build_program();
        if (prog.size() > IMEM_WORDS)
        begin
            $display("Program does not fit the instruction memory");
            stop_run();
        end
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = image_word(i);

        // Strobes low and PC at zero through reset and one cycle after
        for (int c = 0; c < 5; c++)
        begin
            @(posedge clk);
            if (c == 4)
                reset <= 1'b0;
            @(negedge clk);
            check_strobe("dmem_we", dmem_we, 1'b0);
            check_strobe("dmem_re", dmem_re, 1'b0);
            check_addr("imem_addr", imem_addr, '0);
        end

        for (int i = 0; i < exp_addr.size(); i++)
        begin
            wait_store(i);
            check_addr("dmem_addr", dmem_addr, exp_addr[i]);
            check_data("dmem_wdata", dmem_wdata, exp_data[i]);
        end

        cycles = 0;
        while (imem_addr !== idle_addr && cycles < IDLE_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
            if (dmem_we)
            begin
                $display("Unexpected store to address %h after the last expected one", dmem_addr);
                stop_run();
            end
        end
        check_addr("imem_addr", imem_addr, idle_addr);

        for (int c = 0; c < 20; c++)
        begin
            @(negedge clk);
            check_addr("imem_addr", imem_addr, idle_addr);
            check_strobe("dmem_we", dmem_we, 1'b0);
        end
        check_count("load strobes", re_count, loads_expected);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
#(
    parameter int PERIOD = 4        // ns
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: cpu_core.sv
`timescale 1ns/10ps

module cpu_core
    import cpu_pkg::*;
#(
    parameter int PC_W     = 32,
    parameter int NUM_REGS = 32
)
(
    input  logic              clk,
    input  logic              reset,
    output logic [PC_W-1:0]   imem_addr,
    input  logic [DATA_W-1:0] imem_data,
    output logic [DATA_W-1:0] dmem_addr,
    output logic [DATA_W-1:0] dmem_wdata,
    output logic              dmem_we,
    output logic              dmem_re,
    input  logic [DATA_W-1:0] dmem_rdata
);

    logic [DATA_W-1:0]     instr;
    logic [DATA_W-1:0]     load_data;
    logic [DATA_W-1:0]     imm_ext;
    logic [DATA_W-1:0]     rs_value;
    logic [DATA_W-1:0]     rt_value;
    logic [DATA_W-1:0]     alu_result;
    logic [DATA_W-1:0]     link_value;
    logic [DATA_W-1:0]     wb_data;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  branch_taken;
    opcode_t               op_code;
    func_t                 func_code;

    ctrl_if ctrl_bus ();

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    assign op_code   = opcode_t'(instr[31:26]);
    assign func_code = func_t'(instr[10:0]);
    assign imm_ext   = {{(DATA_W-16){instr[15]}}, instr[15:0]};
    assign rd_addr   = ctrl_bus.cw.reg_write_select ? instr[20:16] : instr[25:21];

    always_ff @(posedge clk)
    begin
        if (ctrl_bus.fetch_en)
            instr <= imem_data;
        if (ctrl_bus.mem_en && ctrl_bus.cw.mem_read)
            load_data <= dmem_rdata;                      // Same-cycle read data
    end

    // Link, then ALU result, then load data
    assign wb_data = ctrl_bus.cw.reg_to_pc ? link_value :
                     ctrl_bus.cw.reg_data  ? alu_result : load_data;

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rt_value;
    assign dmem_we    = ctrl_bus.mem_en && ctrl_bus.cw.mem_write;
    assign dmem_re    = ctrl_bus.mem_en && ctrl_bus.cw.mem_read;

    control_decoder u_decoder (
        .op_code   (op_code),
        .func_code (func_code),
        .reset     (reset),
        .ctrl      (ctrl_bus)
    );

    phase_fsm u_fsm (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus)
    );

    program_counter #(.PC_W(PC_W)) u_pc (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl_bus),
        .branch_taken (branch_taken),
        .offset       (imm_ext),
        .jump_target  (rs_value),
        .pc           (imem_addr),
        .link_value   (link_value)
    );

    alu_unit u_alu (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl_bus),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .immediate    (imm_ext),
        .shamt        (instr[15:11]),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    register_file #(.NUM_REGS(NUM_REGS)) u_regs (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl_bus),
        .rs_addr  (instr[25:21]),
        .rt_addr  (instr[20:16]),
        .rd_addr  (rd_addr),
        .wdata    (wb_data),
        .rs_value (rs_value),
        .rt_value (rt_value)
    );

endmodule

// File: register_file.sv
`timescale 1ns/10ps

module register_file
    import cpu_pkg::*;
#(
    parameter int NUM_REGS = 32
)
(
    input  logic                  clk,
    input  logic                  reset,
    ctrl_if.datapath              ctrl,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic [DATA_W-1:0]     wdata,
    output logic [DATA_W-1:0]     rs_value,
    output logic [DATA_W-1:0]     rt_value
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              write_en;

    // Register 0 is hard zero
    assign rs_value = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_value = (rt_addr == '0) ? '0 : regs[rt_addr];

    assign write_en = !reset && ctrl.wb_en && ctrl.cw.reg_write && (rd_addr != '0);

    always_ff @(posedge clk)
    begin
        if (write_en)
            regs[rd_addr] <= wdata;
    end

    a_rd_in_range: assert property (
        @(posedge clk) disable iff (reset)
        (ctrl.wb_en && ctrl.cw.reg_write) |-> (int'(rd_addr) < NUM_REGS)
    );

endmodule

// File: alu_unit.sv
`timescale 1ns/10ps

module alu_unit
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    ctrl_if.datapath          ctrl,
    input  logic [DATA_W-1:0] rs_value,
    input  logic [DATA_W-1:0] rt_value,
    input  logic [DATA_W-1:0] immediate,
    input  logic [4:0]        shamt,
    output logic [DATA_W-1:0] result,
    output logic              branch_taken
);

    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] add_a;
    logic [DATA_W-1:0] add_b;
    logic [DATA_W:0]   sum;
    logic [4:0]        shift;
    logic [DATA_W-1:0] alu_out;
    logic              flag_load;
    logic              zero_flag;
    logic              sign_flag;
    logic              carry_flag;

    //////////////////////////////////////////////////
    // Operands and adder
    //////////////////////////////////////////////////

    assign op_b  = ctrl.cw.alu_src ? immediate : rt_value;
    assign shift = ctrl.cw.const_src ? shamt : rt_value[4:0];
    assign add_a = (ctrl.cw.alu_op == ALU_COMP) ? '0 : rs_value;
    assign add_b = ctrl.cw.ab_set ? ~op_b : op_b;            // Negate B with carry in
    assign sum   = {1'b0, add_a} + {1'b0, add_b} + {{DATA_W{1'b0}}, ctrl.cw.ab_set};

    always_comb
    begin
        case (ctrl.cw.alu_op)
            ALU_ADD, ALU_COMP, ALU_ADDR: alu_out = sum[DATA_W-1:0];
            ALU_AND: alu_out = rs_value & op_b;
            ALU_XOR: alu_out = rs_value ^ op_b;
            ALU_SLL: alu_out = rs_value << shift;
            ALU_SRL: alu_out = rs_value >> shift;
            ALU_SRA: alu_out = $signed(rs_value) >>> shift;
            default: alu_out = op_b;                          // Branch offset
        endcase
    end

    // Only register-writing arithmetic and logic touch the flags
    assign flag_load = ctrl.exec_en && ctrl.cw.reg_data
                       && (ctrl.cw.alu_op inside {[ALU_ADD:ALU_SRA]});

    always_ff @(posedge clk)
    begin
        if (ctrl.exec_en)
            result <= alu_out;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            zero_flag  <= 1'b0;
            sign_flag  <= 1'b0;
            carry_flag <= 1'b0;
        end
        else if (flag_load)
        begin
            zero_flag  <= (alu_out == '0);
            sign_flag  <= alu_out[DATA_W-1];
            carry_flag <= (ctrl.cw.alu_op inside {ALU_ADD, ALU_COMP}) ? sum[DATA_W] : 1'b0;
        end
    end

    always_comb
    begin
        case (ctrl.cw.pc_src)
            PC_BR_ALWAYS: branch_taken = 1'b1;
            PC_BR_NEG:    branch_taken = sign_flag;
            PC_BR_ZERO:   branch_taken = zero_flag;
            PC_BR_NZERO:  branch_taken = !zero_flag;
            PC_BR_CARRY:  branch_taken = carry_flag;
            PC_BR_NCARRY: branch_taken = !carry_flag;
            default:      branch_taken = 1'b0;
        endcase
    end

endmodule

// File: program_counter.sv
`timescale 1ns/10ps

module program_counter
    import cpu_pkg::*;
#(
    parameter int PC_W = 32
)
(
    input  logic              clk,
    input  logic              reset,
    ctrl_if.datapath          ctrl,
    input  logic              branch_taken,
    input  logic [DATA_W-1:0] offset,
    input  logic [DATA_W-1:0] jump_target,
    output logic [PC_W-1:0]   pc,
    output logic [DATA_W-1:0] link_value
);

    logic [PC_W-1:0] pc_plus4;
    logic [PC_W-1:0] branch_target;

    assign pc_plus4      = pc + PC_W'(4);
    assign branch_target = pc_plus4 + PC_W'({offset[DATA_W-3:0], 2'b00});   // Word offset
    assign link_value    = DATA_W'(pc_plus4);

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= '0;
        else if (ctrl.wb_en)
        begin
            if (ctrl.cw.pc_src == PC_JUMP)
                pc <= PC_W'(jump_target);
            else if (branch_taken)
                pc <= branch_target;
            else
                pc <= pc_plus4;
        end
    end

    // A jump through a register can break alignment
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

endmodule

// File: phase_fsm.sv
`timescale 1ns/10ps

module phase_fsm
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    ctrl_if.sequencer ctrl
);

    phase_t state;
    phase_t state_next;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= FETCH;
        else
            state <= state_next;
    end

    // One phase per cycle, five per instruction
    always_comb
    begin
        case (state)
            FETCH:     state_next = DECODE;
            DECODE:    state_next = EXECUTE;
            EXECUTE:   state_next = MEMORY;
            MEMORY:    state_next = WRITEBACK;
            WRITEBACK: state_next = FETCH;
            default:   state_next = FETCH;
        endcase
    end

    assign ctrl.fetch_en = (state == FETCH);
    assign ctrl.exec_en  = (state == EXECUTE);
    assign ctrl.mem_en   = (state == MEMORY);
    assign ctrl.wb_en    = (state == WRITEBACK);     // DECODE drives none

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_enables_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({ctrl.fetch_en, ctrl.exec_en, ctrl.mem_en, ctrl.wb_en})
    );

endmodule

// File: control_decoder.sv
`timescale 1ns/10ps

module control_decoder
    import cpu_pkg::*;
(
    input  opcode_t   op_code,
    input  func_t     func_code,
    input  logic      reset,
    ctrl_if.decoder   ctrl
);

    ctrl_t cw;

    always_comb
    begin
        cw = '0;                            // Also the no-op for unknown codes
        if (!reset)
        begin
            if (op_code == OP_RTYPE)
            begin
                cw.reg_write = 1'b1;
                cw.reg_data  = 1'b1;
                case (func_code)
                    FN_ADD:  cw.alu_op = ALU_ADD;
                    FN_COMP:
                    begin
                        cw.alu_op = ALU_COMP;
                        cw.ab_set = 1'b1;
                    end
                    FN_AND:  cw.alu_op = ALU_AND;
                    FN_XOR:  cw.alu_op = ALU_XOR;
                    FN_SLL_IMM:
                    begin
                        cw.alu_op    = ALU_SLL;
                        cw.alu_src   = 1'b1;
                        cw.const_src = 1'b1;
                    end
                    FN_SRL_IMM:
                    begin
                        cw.alu_op    = ALU_SRL;
                        cw.alu_src   = 1'b1;
                        cw.const_src = 1'b1;
                    end
                    FN_SRA_IMM:
                    begin
                        cw.alu_op    = ALU_SRA;
                        cw.alu_src   = 1'b1;
                        cw.const_src = 1'b1;
                    end
                    FN_SLL_REG: cw.alu_op = ALU_SLL;   // Amount from rt
                    FN_SRL_REG: cw.alu_op = ALU_SRL;
                    FN_SRA_REG: cw.alu_op = ALU_SRA;
                    default:    cw = '0;
                endcase
            end
            else
            begin
                case (op_code)
                    OP_ADDI, OP_COMPI:
                    begin
                        cw.alu_op    = (op_code == OP_COMPI) ? ALU_COMP : ALU_ADD;
                        cw.ab_set    = (op_code == OP_COMPI);
                        cw.reg_write = 1'b1;
                        cw.alu_src   = 1'b1;
                        cw.reg_data  = 1'b1;
                    end
                    OP_LOAD:
                    begin
                        cw.alu_op           = ALU_ADDR;
                        cw.reg_write        = 1'b1;
                        cw.mem_read         = 1'b1;
                        cw.alu_src          = 1'b1;
                        cw.reg_write_select = 1'b1;
                    end
                    OP_STORE:
                    begin
                        cw.alu_op           = ALU_ADDR;
                        cw.mem_write        = 1'b1;
                        cw.alu_src          = 1'b1;
                        cw.reg_write_select = 1'b1;
                    end
                    OP_JR:
                    begin
                        cw.alu_op   = ALU_BRANCH;
                        cw.reg_data = 1'b1;
                        cw.pc_src   = PC_JUMP;
                    end
                    // Link value goes to the rs register
                    OP_BL:
                    begin
                        cw.alu_op    = ALU_ADD;
                        cw.reg_write = 1'b1;
                        cw.alu_src   = 1'b1;
                        cw.reg_to_pc = 1'b1;
                        cw.pc_src    = PC_BR_ALWAYS;
                    end
                    OP_BR, OP_BRN, OP_BRZ:
                    begin
                        cw.alu_op  = ALU_BRANCH;
                        cw.alu_src = 1'b1;
                        cw.pc_src  = (op_code == OP_BR)  ? PC_BR_ALWAYS :
                                     (op_code == OP_BRN) ? PC_BR_NEG : PC_BR_ZERO;
                    end
                    OP_BRNZ, OP_BRC, OP_BRNC:
                    begin
                        cw.alu_op  = ALU_FLAG_BRANCH;
                        cw.alu_src = 1'b1;
                        cw.pc_src  = (op_code == OP_BRNZ) ? PC_BR_NZERO :
                                     (op_code == OP_BRC)  ? PC_BR_CARRY : PC_BR_NCARRY;
                    end
                    default: cw = '0;
                endcase
            end
        end
    end

    assign ctrl.cw = cw;

endmodule

// File: ctrl_if.sv
`timescale 1ns/10ps

interface ctrl_if
    import cpu_pkg::*;
();

    ctrl_t cw;          // Decoded control word
    logic  fetch_en;
    logic  exec_en;
    logic  mem_en;
    logic  wb_en;

    modport decoder (
        output cw
    );

    modport sequencer (
        output fetch_en, exec_en, mem_en, wb_en
    );

    modport datapath (
        input cw, fetch_en, exec_en, mem_en, wb_en
    );

endinterface

// File: cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd1,
        OP_COMPI = 6'd2,
        OP_LOAD  = 6'd3,
        OP_STORE = 6'd4,
        OP_BR    = 6'd5,
        OP_BRN   = 6'd6,
        OP_JR    = 6'd7,
        OP_BRZ   = 6'd8,
        OP_BRNZ  = 6'd9,
        OP_BL    = 6'd10,
        OP_BRC   = 6'd11,
        OP_BRNC  = 6'd12
    } opcode_t;

    // R-type function codes
    typedef enum logic [10:0] {
        FN_ADD     = 11'd0,
        FN_COMP    = 11'd1,
        FN_AND     = 11'd2,
        FN_XOR     = 11'd3,
        FN_SLL_IMM = 11'd4,
        FN_SRL_IMM = 11'd5,
        FN_SLL_REG = 11'd6,
        FN_SRL_REG = 11'd7,
        FN_SRA_IMM = 11'd8,
        FN_SRA_REG = 11'd9
    } func_t;

    typedef enum logic [3:0] {
        ALU_ADD         = 4'd0,
        ALU_COMP        = 4'd1,
        ALU_AND         = 4'd2,
        ALU_XOR         = 4'd3,
        ALU_SLL         = 4'd4,
        ALU_SRL         = 4'd5,
        ALU_SRA         = 4'd6,
        ALU_BRANCH      = 4'd7,   // Relative target
        ALU_FLAG_BRANCH = 4'd8,   // Flag-tested target
        ALU_ADDR        = 4'd9    // Load and store address
    } alu_op_t;

    // Next-PC source and branch condition
    typedef enum logic [2:0] {
        PC_NEXT      = 3'd0,
        PC_JUMP      = 3'd1,
        PC_BR_ALWAYS = 3'd2,
        PC_BR_NEG    = 3'd3,
        PC_BR_ZERO   = 3'd4,
        PC_BR_NZERO  = 3'd5,
        PC_BR_CARRY  = 3'd6,
        PC_BR_NCARRY = 3'd7
    } pc_src_t;

    typedef struct packed {
        alu_op_t alu_op;
        pc_src_t pc_src;
        logic    ab_set;
        logic    reg_write;
        logic    mem_write;
        logic    mem_read;
        logic    alu_src;
        logic    reg_data;
        logic    const_src;
        logic    reg_to_pc;
        logic    reg_write_select;
    } ctrl_t;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } phase_t;

endpackage
